// ==== common/core_cfg_pkg.sv ====
//----------------------------------------------------------------------
// Core-wide configuration: sequence number and redirect address widths
// and the matching types
//----------------------------------------------------------------------

`default_nettype none

package core_cfg_pkg;

  // 5-bit tags, 32 instructions in flight
  localparam int unsigned seq_num_bits = 5;

  // Redirect target width
  localparam int unsigned addr_bits = 32;

  // Instruction sequence number, wraps modulo 2^seq_num_bits
  typedef logic [seq_num_bits-1:0] seq_num_t;

  // Fetch redirect address
  typedef logic [addr_bits-1:0] addr_t;

endpackage

`default_nettype wire

// ==== common/squash_pkg.sv ====
//----------------------------------------------------------------------
// Squash notification message and the wraparound-aware age compare
//----------------------------------------------------------------------

`default_nettype none

package squash_pkg;

  import core_cfg_pkg::*;

  //--------------------------------------------------------------------
  // Squash message
  //--------------------------------------------------------------------

  // 38 bits with the default widths
  typedef struct packed {
    logic     val;
    seq_num_t seq_num;
    addr_t    target;
  } squash_msg_t;

  //--------------------------------------------------------------------
  // Age comparison
  //--------------------------------------------------------------------

  // True when a is strictly older than b, i.e. nearer the commit head
  // Distances count forward from head and wrap with the tag width
  function automatic logic is_older(seq_num_t a, seq_num_t b, seq_num_t head);
    seq_num_t dist_a;
    seq_num_t dist_b;
    // Modular subtraction handles the wrap
    dist_a = a - head;
    dist_b = b - head;
    return dist_a < dist_b;
  endfunction

endpackage

`default_nettype wire

// ==== hw/squash/squash_arb_node.sv ====
//----------------------------------------------------------------------
// Pairwise squash arbiter: passes the older of two notifications,
// purely combinational
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module squash_arb_node
  import core_cfg_pkg::*;
  import squash_pkg::*;
(
  // Commit head, reference point for age
  input  seq_num_t    head,

  // Notifications to compare
  input  squash_msg_t arb0,
  input  squash_msg_t arb1,

  // Winner
  output squash_msg_t gnt
);

  // Age of arb0 relative to arb1
  logic arb0_older;

  assign arb0_older = is_older(arb0.seq_num, arb1.seq_num, head);

  always_comb begin
    if (!arb0.val) begin
      // Only arb1 can be valid, or neither
      gnt = arb1;
    end else if (!arb1.val) begin
      gnt = arb0;
    end else if (arb0_older) begin
      // Both valid, arb0 strictly older
      gnt = arb0;
    end else begin
      // Both valid, ties go to arb1
      gnt = arb1;
    end
  end

endmodule

`default_nettype wire

// ==== hw/squash/squash_arb_tree.sv ====
//----------------------------------------------------------------------
// Binary tree of pairwise squash arbiters over num_arb sources, leaves
// padded to a power of two with invalid messages
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module squash_arb_tree
  import core_cfg_pkg::*;
  import squash_pkg::*;
#(
  parameter int unsigned num_arb = 2
) (
  // Commit head, fanned out to every node
  input  seq_num_t    head,

  // Source notifications
  input  squash_msg_t arb [num_arb],

  // Oldest valid notification
  output squash_msg_t gnt
);

  // Tree shape
  localparam int unsigned num_levels = $clog2(num_arb);
  localparam int unsigned num_leaves = 2 ** num_levels;
  localparam int unsigned num_nodes  = 2 * num_leaves - 1;

  // OR of all source valids, for checking
  logic any_val;

  generate
    if (num_arb == 1) begin : g_single
      // Nothing to arbitrate
      assign gnt = arb[0];
    end else begin : g_tree
      // Heap layout, root at 0, children of i at 2i+1 and 2i+2
      squash_msg_t node_msg [num_nodes];

      //----------------------------------------------------------------
      // Leaves
      //----------------------------------------------------------------

      for (genvar k = 0; k < num_leaves; k++) begin : g_leaf
        if (k < num_arb) begin : g_src
          assign node_msg[num_leaves-1+k] = arb[k];
        end else begin : g_pad
          // Unused leaf never wins
          assign node_msg[num_leaves-1+k] = '0;
        end
      end

      //----------------------------------------------------------------
      // Internal nodes
      //----------------------------------------------------------------

      for (genvar i = 0; i < num_leaves - 1; i++) begin : g_node
        squash_arb_node u_node (
          .head (head),
          .arb0 (node_msg[2*i+1]),
          .arb1 (node_msg[2*i+2]),
          .gnt  (node_msg[i])
        );
      end

      assign gnt = node_msg[0];
    end
  endgenerate

  always_comb begin
    any_val = 1'b0;
    for (int k = 0; k < num_arb; k++) begin
      any_val = any_val | arb[k].val;
    end
  end

  // A grant exists exactly when some source raised a notification
  // Checked once the tree has settled
  always_comb begin
    assert final (gnt.val == any_val)
      else $error("squash_arb_tree: gnt.val %b with any source valid %b", gnt.val, any_val);
  end

endmodule

`default_nettype wire

// ==== hw/squash/squash_ctrl.sv ====
//----------------------------------------------------------------------
// Squash control: commit head, younger-squash filter and the
// registered squash output
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module squash_ctrl
  import core_cfg_pkg::*;
  import squash_pkg::*;
(
  input  logic        clk,
  input  logic        rst_n,

  // Arbitrated notification from the tree
  input  squash_msg_t gnt,

  // Retirement strobe
  input  logic        commit_val,
  input  seq_num_t    commit_seq_num,

  // Next instruction to retire
  output seq_num_t    head,

  // Issued squash
  output squash_msg_t squash
);

  //--------------------------------------------------------------------
  // State
  //--------------------------------------------------------------------

  seq_num_t head_q;

  // Filter drops anything younger than filt_seq_num
  logic     filt_val;
  seq_num_t filt_seq_num;

  // Output register
  logic     squash_val_q;
  seq_num_t squash_seq_q;
  addr_t    squash_target_q;

  //--------------------------------------------------------------------
  // Accept decision
  //--------------------------------------------------------------------

  logic accept;
  logic filt_clear;

  // Grant must be older than the last issued squash while filtering
  assign accept = gnt.val &&
                  (!filt_val || is_older(gnt.seq_num, filt_seq_num, head_q));

  // Squashing instruction retires
  assign filt_clear = commit_val && filt_val && (commit_seq_num == filt_seq_num);

  //--------------------------------------------------------------------
  // Control registers
  //--------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      head_q       <= '0;
      filt_val     <= 1'b0;
      squash_val_q <= 1'b0;
    end else begin
      if (commit_val) begin
        head_q <= commit_seq_num + seq_num_t'(1);
      end
      // New squash wins over a same-cycle clear
      if (accept) begin
        filt_val <= 1'b1;
      end else if (filt_clear) begin
        filt_val <= 1'b0;
      end
      squash_val_q <= accept;
    end
  end

  // Payload, loaded only on issue
  always_ff @(posedge clk) begin
    if (accept) begin
      filt_seq_num    <= gnt.seq_num;
      squash_seq_q    <= gnt.seq_num;
      squash_target_q <= gnt.target;
    end
  end

  assign head   = head_q;
  assign squash = '{val: squash_val_q, seq_num: squash_seq_q, target: squash_target_q};

  //--------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------

  // Retirement is in order, always at the head
  a_commit_at_head: assert property (@(posedge clk) disable iff (!rst_n)
    commit_val |-> commit_seq_num == head_q);

  // Issued squash is last cycle's grant
  a_squash_from_gnt: assert property (@(posedge clk) disable iff (!rst_n)
    squash_val_q |-> $past(gnt.val) && squash_seq_q == $past(gnt.seq_num));

endmodule

`default_nettype wire

// ==== hw/squash_top.sv ====
//----------------------------------------------------------------------
// Squash arbitration top: packs source ports into messages, arbiter
// tree followed by the squash control
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module squash_top
  import core_cfg_pkg::*;
  import squash_pkg::*;
#(
  parameter int unsigned num_arb = 4
) (
  input  logic               clk,
  input  logic               rst_n,

  // Squash sources
  input  logic [num_arb-1:0] arb_val,
  input  seq_num_t           arb_seq_num [num_arb],
  input  addr_t              arb_target  [num_arb],

  // Retirement
  input  logic               commit_val,
  input  seq_num_t           commit_seq_num,

  // Issued squash
  output logic               squash_val,
  output seq_num_t           squash_seq_num,
  output addr_t              squash_target
);

  squash_msg_t arb_msg [num_arb];
  squash_msg_t gnt;
  squash_msg_t squash;
  seq_num_t    head;

  // Pack each source
  for (genvar k = 0; k < num_arb; k++) begin : g_pack
    assign arb_msg[k] = '{val: arb_val[k], seq_num: arb_seq_num[k], target: arb_target[k]};
  end

  squash_arb_tree #(
    .num_arb (num_arb)
  ) u_tree (
    .head (head),
    .arb  (arb_msg),
    .gnt  (gnt)
  );

  squash_ctrl u_ctrl (
    .clk            (clk),
    .rst_n          (rst_n),
    .gnt            (gnt),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .head           (head),
    .squash         (squash)
  );

  // Unpack onto the output ports
  assign squash_val     = squash.val;
  assign squash_seq_num = squash.seq_num;
  assign squash_target  = squash.target;

endmodule

`default_nettype wire

// ==== bench/squash_tb.sv ====
//----------------------------------------------------------------------
// Directed testbench for the squash arbitration top level
// Reference model of head and filter, Galois LFSR, compare task and
// watchdog
//----------------------------------------------------------------------

`timescale 1ns/1ps
`default_nettype none

module squash_tb
  import core_cfg_pkg::*;
();

  localparam int num_arb         = 4;
  localparam int num_tests       = 6;
  localparam int max_test_cycles = 250;
  localparam int clk_period      = 20;
  // Twice the longest possible run
  localparam longint watchdog_ns = num_tests * max_test_cycles * clk_period * 2;

  logic               clk;
  logic               rst_n;
  logic [num_arb-1:0] arb_val;
  seq_num_t           arb_seq_num [num_arb];
  addr_t              arb_target  [num_arb];
  logic               commit_val;
  seq_num_t           commit_seq_num;
  logic               squash_val;
  seq_num_t           squash_seq_num;
  addr_t              squash_target;

  // Reference model state
  seq_num_t    m_head;
  logic        m_filt_val;
  seq_num_t    m_filt_seq;
  logic [31:0] lfsr_state;
  int          err_count;
  int          pass_count;
  int          fail_count;

  squash_top #(
    .num_arb (num_arb)
  ) u_dut (
    .clk            (clk),
    .rst_n          (rst_n),
    .arb_val        (arb_val),
    .arb_seq_num    (arb_seq_num),
    .arb_target     (arb_target),
    .commit_val     (commit_val),
    .commit_seq_num (commit_seq_num),
    .squash_val     (squash_val),
    .squash_seq_num (squash_seq_num),
    .squash_target  (squash_target)
  );

  initial clk = 1'b0;
  always #(clk_period / 2) clk = ~clk;

  //--------------------------------------------------------------------
  // Helpers
  //--------------------------------------------------------------------

  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] lfsr_bits(int n);
    logic [31:0] r;
    r = '0;
    for (int i = 0; i < n; i++) begin
      r[i] = lfsr_state[0];
      if (lfsr_state[0]) begin
        lfsr_state = (lfsr_state >> 1) ^ 32'h8020_0003;
      end else begin
        lfsr_state = lfsr_state >> 1;
      end
    end
    return r;
  endfunction

  // Forward distance from head, modulo the tag space
  function automatic int tag_dist(seq_num_t a, seq_num_t head);
    return (int'(a) - int'(head) + 2 ** seq_num_bits) % (2 ** seq_num_bits);
  endfunction

  function automatic logic model_older(seq_num_t a, seq_num_t b, seq_num_t head);
    return tag_dist(a, head) < tag_dist(b, head);
  endfunction

  task automatic compare(string name, logic [63:0] exp, logic [63:0] act);
    if (exp !== act) begin
      $display("Error: %0t ns %s expected %0h got %0h", $time, name, exp, act);
      err_count++;
    end
  endtask

  task automatic drive_idle();
    arb_val        = '0;
    commit_val     = 1'b0;
    commit_seq_num = '0;
    for (int k = 0; k < num_arb; k++) begin
      arb_seq_num[k] = '0;
      arb_target[k]  = '0;
    end
  endtask

  task automatic raise(int k, seq_num_t seq, addr_t target);
    arb_val[k]     = 1'b1;
    arb_seq_num[k] = seq;
    arb_target[k]  = target;
  endtask

  // One clock with the current inputs, model update and output check
  task automatic run_cycle();
    int       best;
    logic     take;
    logic     clr;
    seq_num_t exp_seq;
    addr_t    exp_target;
    best = -1;
    // Oldest valid source, ties go to the higher index
    for (int k = 0; k < num_arb; k++) begin
      if (arb_val[k]) begin
        if (best < 0) begin
          best = k;
        end else if (!model_older(arb_seq_num[best], arb_seq_num[k], m_head)) begin
          best = k;
        end
      end
    end
    take = 1'b0;
    exp_seq = '0;
    exp_target = '0;
    if (best >= 0) begin
      exp_seq    = arb_seq_num[best];
      exp_target = arb_target[best];
      take = !m_filt_val || model_older(exp_seq, m_filt_seq, m_head);
    end
    clr = commit_val && m_filt_val && (commit_seq_num == m_filt_seq);
    @(posedge clk);
    #2;
    if (commit_val) begin
      m_head = commit_seq_num + seq_num_t'(1);
    end
    // New squash beats a same-cycle clear
    if (take) begin
      m_filt_val = 1'b1;
      m_filt_seq = exp_seq;
    end else if (clr) begin
      m_filt_val = 1'b0;
    end
    compare("squash_val", take, squash_val);
    if (take) begin
      compare("squash_seq_num", exp_seq, squash_seq_num);
      compare("squash_target", exp_target, squash_target);
    end
    drive_idle();
  endtask

  task automatic commit_head();
    commit_val     = 1'b1;
    commit_seq_num = m_head;
    run_cycle();
  endtask

  task automatic end_test(string name, int errs_at_start);
    int n;
    n = err_count - errs_at_start;
    if (n == 0) begin
      pass_count++;
    end else begin
      fail_count++;
    end
    $display("test %s finished with %0d errors", name, n);
  endtask

  //--------------------------------------------------------------------
  // Tests
  //--------------------------------------------------------------------

  task automatic test_reset_idle();
    int e0;
    e0 = err_count;
    compare("squash_val", 1'b0, squash_val);
    repeat (5) run_cycle();
    end_test("reset_idle", e0);
  endtask

  task automatic test_single_source();
    int e0;
    e0 = err_count;
    raise(2, 5'd3, 32'h0000_4a10);
    run_cycle();
    compare("squash_seq_num", 5'd3, squash_seq_num);
    run_cycle();
    end_test("single_source", e0);
  endtask

  task automatic test_oldest_wrap();
    int e0;
    e0 = err_count;
    // Head to 30, passing 3 clears the filter
    while (m_head != 5'd30) begin
      commit_head();
    end
    raise(0, 5'd1, 32'h1000_0001);
    raise(1, 5'd31, 32'h1000_001f);
    raise(2, 5'd5, 32'h1000_0005);
    raise(3, 5'd0, 32'h1000_0000);
    run_cycle();
    compare("squash_seq_num", 5'd31, squash_seq_num);
    end_test("oldest_wrap", e0);
  endtask

  task automatic test_filter();
    int e0;
    e0 = err_count;
    // Younger than 31, dropped
    raise(0, 5'd2, 32'h2000_0002);
    run_cycle();
    compare("squash_val", 1'b0, squash_val);
    // Older, replaces 31
    raise(3, 5'd30, 32'h2000_001e);
    run_cycle();
    compare("squash_val", 1'b1, squash_val);
    raise(1, 5'd31, 32'h2000_001f);
    run_cycle();
    end_test("filter", e0);
  endtask

  task automatic test_filter_clear();
    int e0;
    e0 = err_count;
    commit_head();
    // Tag 30 reused by a younger instruction
    // Still blocked if the filter on 30 stayed up
    raise(1, 5'd30, 32'h3000_001e);
    run_cycle();
    compare("squash_val", 1'b1, squash_val);
    end_test("filter_clear", e0);
  endtask

  task automatic test_random();
    int e0;
    e0 = err_count;
    for (int c = 0; c < 200; c++) begin
      for (int k = 0; k < num_arb; k++) begin
        if (lfsr_bits(1) != 0) begin
          raise(k, m_head + seq_num_t'(lfsr_bits(4)), lfsr_bits(32));
        end
      end
      if (lfsr_bits(1) != 0) begin
        commit_val     = 1'b1;
        commit_seq_num = m_head;
      end
      run_cycle();
    end
    end_test("random", e0);
  endtask

  //--------------------------------------------------------------------
  // Main sequence and watchdog
  //--------------------------------------------------------------------

  initial begin
    drive_idle();
    rst_n      = 1'b0;
    lfsr_state = 32'd96471;
    m_head     = '0;
    m_filt_val = 1'b0;
    m_filt_seq = '0;
    err_count  = 0;
    pass_count = 0;
    fail_count = 0;
    repeat (3) @(posedge clk);
    #2;
    rst_n = 1'b1;
    test_reset_idle();
    test_single_source();
    test_oldest_wrap();
    test_filter();
    test_filter_clear();
    test_random();
    $display("summary: %0d passed, %0d failed, %0d mismatches",
             pass_count, fail_count, err_count);
    if (fail_count == 0) begin
      $display("all tests passed");
    end else begin
      $display("tests failed");
    end
    $finish;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog: run did not complete within %0d ns", watchdog_ns);
    $display("tests failed");
    $finish;
  end

endmodule

`default_nettype wire

// ==== tb.f ====
common/core_cfg_pkg.sv
common/squash_pkg.sv
hw/squash/squash_arb_node.sv
hw/squash/squash_arb_tree.sv
hw/squash/squash_ctrl.sv
hw/squash_top.sv
bench/squash_tb.sv

// ==== Bender.yml ====
package:
  name: squash_arb

sources:
  # Packages
  - common/core_cfg_pkg.sv
  - common/squash_pkg.sv
  # RTL
  - hw/squash/squash_arb_node.sv
  - hw/squash/squash_arb_tree.sv
  - hw/squash/squash_ctrl.sv
  - hw/squash_top.sv
  # Testbench
  - target: test
    files:
      - bench/squash_tb.sv
